// ==== common/mipsIsaPkg.sv ====
package mipsIsaPkg;

	// instruction field widths
	localparam int opW = 6;
	localparam int functW = 6;
	localparam int regW = 5;
	localparam int immW = 16;
	localparam int shamtW = 5;
	localparam int jumpW = 26;

	typedef logic [regW-1:0] regIdxT;
	typedef logic [31:0] wordT;

	// major opcodes, everything else decodes as a no-op
	typedef enum logic [opW-1:0] {
		opRType = 6'h00,
		opJ     = 6'h02,
		opBeq   = 6'h04,
		opBne   = 6'h05,
		opAddiu = 6'h09,
		opSlti  = 6'h0a,
		opAndi  = 6'h0c,
		opOri   = 6'h0d,
		opLui   = 6'h0f,
		opLw    = 6'h23,
		opSw    = 6'h2b
	} opcodeT;

	typedef enum logic [functW-1:0] {
		fnSll  = 6'h00,
		fnSrl  = 6'h02,
		fnAddu = 6'h21,
		fnSubu = 6'h23,
		fnAnd  = 6'h24,
		fnOr   = 6'h25,
		fnXor  = 6'h26,
		fnSlt  = 6'h2a
	} functT;

	localparam wordT ioAddr = 32'h8000_0000; // stores here go to the output port

endpackage

// ==== common/mipsCtrlPkg.sv ====
package mipsCtrlPkg;

	typedef enum logic [3:0] {
		aluAdd,
		aluSub,
		aluAnd,
		aluOr,
		aluXor,
		aluSlt,
		aluSll,
		aluSrl,
		aluLui
	} aluOpT;

	// source of the second ALU operand
	typedef enum logic [1:0] {
		srcReg,
		srcSImm,
		srcZImm
	} srcBT;

	typedef enum logic [1:0] {
		brNone,
		brEq,
		brNe,
		brJump
	} branchT;

	typedef struct packed {
		aluOpT aluOp;
		srcBT srcB;
		branchT branch;
		logic regWrite;
		logic memToReg;
		logic memWrite;
		logic destIsRt; // I-type results land in rt
	} ctrlT;

	localparam ctrlT ctrlNop = '{aluOp: aluAdd, srcB: srcReg, branch: brNone,
		regWrite: 1'b0, memToReg: 1'b0, memWrite: 1'b0, destIsRt: 1'b0};

endpackage

// ==== common/execResultIf.sv ====
interface execResultIf import mipsIsaPkg::*, mipsCtrlPkg::*; ();

	logic valid;
	ctrlT ctrl;
	regIdxT dest;
	wordT aluResult;

	// forwarding from the result stage back into execute
	logic fwdValid;
	regIdxT fwdDest;
	wordT fwdData;

	modport exec (
		output valid, ctrl, dest, aluResult,
		input fwdValid, fwdDest, fwdData
	);

	modport result (
		input valid, ctrl, dest, aluResult,
		output fwdValid, fwdDest, fwdData
	);

endinterface

// ==== rtl/instDecoder.sv ====
module instDecoder import mipsIsaPkg::*, mipsCtrlPkg::*; (
	input wordT instr,
	output ctrlT ctrl,
	output regIdxT rs,
	output regIdxT rt,
	output regIdxT dest,
	output logic [immW-1:0] imm,
	output logic [shamtW-1:0] shamt,
	output logic [jumpW-1:0] jumpIndex
);

	opcodeT opcode;
	functT funct;
	regIdxT rd;

	assign opcode = opcodeT'(instr[31:26]);
	assign funct = functT'(instr[5:0]);
	assign rs = instr[25:21];
	assign rt = instr[20:16];
	assign rd = instr[15:11];
	assign shamt = instr[10:6];
	assign imm = instr[15:0];
	assign jumpIndex = instr[25:0];

	always_comb begin
		ctrl = ctrlNop;
		case (opcode)
			opRType: begin
				ctrl.regWrite = 1'b1;
				case (funct)
					fnAddu: ctrl.aluOp = aluAdd;
					fnSubu: ctrl.aluOp = aluSub;
					fnAnd: ctrl.aluOp = aluAnd;
					fnOr: ctrl.aluOp = aluOr;
					fnXor: ctrl.aluOp = aluXor;
					fnSlt: ctrl.aluOp = aluSlt;
					fnSll: ctrl.aluOp = aluSll;
					fnSrl: ctrl.aluOp = aluSrl;
					default: ctrl.regWrite = 1'b0; // unknown funct does nothing
				endcase
			end
			opAddiu, opSlti, opLw: begin
				ctrl.aluOp = (opcode == opSlti) ? aluSlt : aluAdd;
				ctrl.srcB = srcSImm;
				ctrl.regWrite = 1'b1;
				ctrl.memToReg = (opcode == opLw);
				ctrl.destIsRt = 1'b1;
			end
			opAndi, opOri: begin
				ctrl.aluOp = (opcode == opAndi) ? aluAnd : aluOr;
				ctrl.srcB = srcZImm; // logical immediates are zero extended
				ctrl.regWrite = 1'b1;
				ctrl.destIsRt = 1'b1;
			end
			opLui: begin
				ctrl.aluOp = aluLui;
				ctrl.regWrite = 1'b1;
				ctrl.destIsRt = 1'b1;
			end
			opSw: begin
				ctrl.srcB = srcSImm;
				ctrl.memWrite = 1'b1;
			end
			opBeq: ctrl.branch = brEq;
			opBne: ctrl.branch = brNe;
			opJ: ctrl.branch = brJump;
			default: ctrl = ctrlNop;
		endcase
	end

	assign dest = ctrl.destIsRt ? rt : rd;

endmodule

// ==== rtl/regFile.sv ====
module regFile import mipsIsaPkg::*; (
	input logic clk,
	input logic we,
	input regIdxT ra1,
	input regIdxT ra2,
	input regIdxT wa,
	input wordT wd,
	output wordT rd1,
	output wordT rd2
);

	wordT regs [32];

	always_ff @(posedge clk) begin
		if (we && wa != '0) begin
			regs[wa] <= wd;
		end
	end

	// register zero always reads as zero
	assign rd1 = (ra1 == '0) ? '0 : regs[ra1];
	assign rd2 = (ra2 == '0) ? '0 : regs[ra2];

endmodule

// ==== rtl/aluExec.sv ====
module aluExec import mipsIsaPkg::*, mipsCtrlPkg::*; #(
	parameter int addrW = 10
) (
	input ctrlT ctrl,
	input wordT rd1,
	input wordT rd2,
	input regIdxT rs,
	input regIdxT rt,
	input regIdxT dest,
	input logic [immW-1:0] imm,
	input logic [shamtW-1:0] shamt,
	input logic [jumpW-1:0] jumpIndex,
	input wordT pcPlus4,
	input logic inValid,
	input logic stall,
	output logic [addrW-1:0] memAddr,
	output logic memWe,
	output wordT memWData,
	output logic ioWe,
	output logic redirect,
	output wordT target,
	execResultIf.exec exec
);

	wordT opA, regB, opB, sImm, zImm, result;
	logic taken, isIo, doStore;

	// the instruction one ahead is still in the result stage
	assign opA = (exec.fwdValid && exec.fwdDest == rs) ? exec.fwdData : rd1;
	assign regB = (exec.fwdValid && exec.fwdDest == rt) ? exec.fwdData : rd2;
	assign sImm = {{16{imm[15]}}, imm};
	assign zImm = {16'h0000, imm};

	always_comb begin
		case (ctrl.srcB)
			srcSImm: opB = sImm;
			srcZImm: opB = zImm;
			default: opB = regB;
		endcase
	end

	always_comb begin
		case (ctrl.aluOp)
			aluSub: result = opA - opB;
			aluAnd: result = opA & opB;
			aluOr: result = opA | opB;
			aluXor: result = opA ^ opB;
			aluSlt: result = {31'b0, $signed(opA) < $signed(opB)};
			aluSll: result = opB << shamt;
			aluSrl: result = opB >> shamt;
			aluLui: result = {imm, 16'h0000};
			default: result = opA + opB;
		endcase
	end

	always_comb begin
		case (ctrl.branch)
			brEq: taken = (opA == regB);
			brNe: taken = (opA != regB);
			brJump: taken = 1'b1;
			default: taken = 1'b0;
		endcase
	end

	assign redirect = inValid && taken;
	assign target = (ctrl.branch == brJump) ? {pcPlus4[31:28], jumpIndex, 2'b00}
		: pcPlus4 + {sImm[29:0], 2'b00};

	assign isIo = (result == ioAddr);
	assign doStore = inValid && ctrl.memWrite && !stall;
	assign memWe = doStore && !isIo;
	assign ioWe = doStore && isIo;
	assign memAddr = result[addrW+1:2]; // word address
	assign memWData = regB;

	assign exec.valid = inValid;
	assign exec.ctrl = ctrl;
	assign exec.dest = dest;
	assign exec.aluResult = result;

endmodule

// ==== rtl/resultSel.sv ====
module resultSel import mipsIsaPkg::*, mipsCtrlPkg::*; (
	input logic clk,
	input logic rstN,
	input logic stall,
	input wordT loadData,
	output logic rfWe,
	output regIdxT rfWa,
	output wordT rfWd,
	execResultIf.result result
);

	logic validQ;
	ctrlT ctrlQ;
	regIdxT destQ;
	wordT aluQ;
	logic writes;

	always_ff @(posedge clk) begin
		if (!rstN) begin
			validQ <= 1'b0;
		end else if (!stall) begin
			validQ <= result.valid;
		end
	end

	always_ff @(posedge clk) begin
		if (!stall) begin
			ctrlQ <= result.ctrl;
			destQ <= result.dest;
			aluQ <= result.aluResult;
		end
	end

	// a write to register zero has no effect, so it is never forwarded
	assign writes = validQ && ctrlQ.regWrite && destQ != '0;

	assign rfWd = ctrlQ.memToReg ? loadData : aluQ; // load data arrives this cycle
	assign rfWa = destQ;
	assign rfWe = writes && !stall;

	assign result.fwdValid = writes;
	assign result.fwdDest = destQ;
	assign result.fwdData = rfWd;

endmodule

// ==== rtl/blockRam.sv ====
module blockRam import mipsIsaPkg::*; #(
	parameter int addrW = 10
) (
	input logic clk,
	input logic we,
	input logic [addrW-1:0] wAddr,
	input wordT wData,
	input logic [addrW-1:0] rAddr,
	output wordT rData
);

	wordT mem [2**addrW];

	// a read of the address being written returns the old word
	always_ff @(posedge clk) begin
		if (we) begin
			mem[wAddr] <= wData;
		end
		rData <= mem[rAddr];
	end

endmodule

// ==== rtl/mipsTop.sv ====
module mipsTop import mipsIsaPkg::*, mipsCtrlPkg::*; #(
	parameter int addrW = 10
) (
	input logic clk,
	input logic rstN,
	input logic stall,
	input logic progWe,
	input logic [addrW-1:0] progAddr,
	input wordT progData,
	output wordT ioData,
	output logic ioValid
);

	wordT pc, pcNext, pcExec, pcPlus4, instr;
	logic fetchValid;
	logic [addrW-1:0] iRdAddr, dRdAddr, dRdAddrQ;
	ctrlT ctrl;
	regIdxT rs, rt, dest;
	logic [immW-1:0] imm;
	logic [shamtW-1:0] shamt;
	logic [jumpW-1:0] jumpIndex;
	wordT rd1, rd2, memWData, target, loadData, rfWd;
	logic [addrW-1:0] memAddr;
	logic memWe, ioWe, redirect, rfWe, ioValidQ;
	regIdxT rfWa;

	execResultIf erIf ();

	// pc is the address being fetched, pcExec the one in execute
	assign pcPlus4 = pcExec + 32'd4;
	assign pcNext = redirect ? target : pc + 32'd4; // redirect lands after the delay slot

	always_ff @(posedge clk) begin
		if (!rstN) begin
			pc <= '0;
			pcExec <= '0;
			fetchValid <= 1'b0;
		end else if (!stall) begin
			pc <= pcNext;
			pcExec <= pc;
			fetchValid <= 1'b1;
		end
	end

	// while stalled, re-read the word in execute so the fetched instruction holds
	assign iRdAddr = stall ? pcExec[addrW+1:2] : pc[addrW+1:2];

	blockRam #(.addrW(addrW)) i_instMem (
		.clk(clk), .we(progWe), .wAddr(progAddr), .wData(progData),
		.rAddr(iRdAddr), .rData(instr)
	);

	instDecoder i_instDecoder (
		.instr(instr), .ctrl(ctrl), .rs(rs), .rt(rt), .dest(dest),
		.imm(imm), .shamt(shamt), .jumpIndex(jumpIndex)
	);

	regFile i_regFile (
		.clk(clk), .we(rfWe), .ra1(rs), .ra2(rt), .wa(rfWa), .wd(rfWd),
		.rd1(rd1), .rd2(rd2)
	);

	aluExec #(.addrW(addrW)) i_aluExec (
		.ctrl(ctrl), .rd1(rd1), .rd2(rd2), .rs(rs), .rt(rt), .dest(dest),
		.imm(imm), .shamt(shamt), .jumpIndex(jumpIndex), .pcPlus4(pcPlus4),
		.inValid(fetchValid), .stall(stall), .memAddr(memAddr), .memWe(memWe),
		.memWData(memWData), .ioWe(ioWe), .redirect(redirect), .target(target),
		.exec(erIf.exec)
	);

	// keep the load address of the result stage alive across a stall
	always_ff @(posedge clk) begin
		if (!stall) begin
			dRdAddrQ <= memAddr;
		end
	end

	assign dRdAddr = stall ? dRdAddrQ : memAddr;

	blockRam #(.addrW(addrW)) i_dataMem (
		.clk(clk), .we(memWe), .wAddr(memAddr), .wData(memWData),
		.rAddr(dRdAddr), .rData(loadData)
	);

	resultSel i_resultSel (
		.clk(clk), .rstN(rstN), .stall(stall), .loadData(loadData),
		.rfWe(rfWe), .rfWa(rfWa), .rfWd(rfWd), .result(erIf.result)
	);

	always_ff @(posedge clk) begin
		if (!rstN) begin
			ioValidQ <= 1'b0;
		end else if (!stall) begin
			ioValidQ <= ioWe;
		end
	end

	always_ff @(posedge clk) begin
		if (ioWe) begin
			ioData <= memWData;
		end
	end

	assign ioValid = ioValidQ && !stall; // a held strobe shows once stall drops

endmodule

// ==== dv/mipsCore_checker.sv ====
module mipsCore_checker import mipsIsaPkg::*; (
	input logic clk,
	input logic rstN,
	input logic stall,
	input logic ioValid,
	input wordT pc,
	input wordT target,
	input logic redirect,
	input logic rfWe,
	input regIdxT rfWa
);
	timeunit 1ns;
	timeprecision 100ps;

	int failCount = 0; // read by the testbench at the end of the run

	noIoWhileStalled: assert property (@(posedge clk) stall |-> !ioValid)
		else begin failCount++; $error("ioValid is high while stall is high"); end

	noIoAfterReset: assert property (@(posedge clk) !rstN |=> !ioValid)
		else begin failCount++; $error("ioValid is high in the first cycle after reset"); end

	// an unstalled cycle moves the fetch address by one word or onto the branch target
	pcStep: assert property (@(posedge clk) disable iff (!rstN)
		!stall |=> pc == ($past(redirect) ? $past(target) : $past(pc) + 32'd4))
		else begin failCount++; $error("pc moved neither by 4 nor to the target"); end

	noZeroWrite: assert property (@(posedge clk) rfWe |-> rfWa != '0)
		else begin failCount++; $error("register write aimed at register zero"); end

endmodule

// ==== dv/mipsTb.sv ====
module mipsTb import mipsIsaPkg::*; ();
	timeunit 1ns;
	timeprecision 100ps;

	localparam int addrW = 10;
	localparam wordT doneWord = 32'hD0E5_0F00; // last word of every program

	logic clk, rstN, stall, progWe, ioValid;
	logic [addrW-1:0] progAddr;
	wordT progData, ioData;
	wordT prog[$], expWords[$], ioWords[$];
	logic sawDone = 1'b0;
	integer seed = 32'h13bee18b;
	int cycleCount = 0;
	int cycleBudget = 64;

	mipsTop #(.addrW(addrW)) i_mipsTop (
		.clk(clk), .rstN(rstN), .stall(stall), .progWe(progWe), .progAddr(progAddr),
		.progData(progData), .ioData(ioData), .ioValid(ioValid)
	);

	bind mipsTop mipsCore_checker i_coreChecker (
		.clk(clk), .rstN(rstN), .stall(stall), .ioValid(ioValid), .pc(pc), .target(target),
		.redirect(redirect), .rfWe(rfWe), .rfWa(rfWa)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	always @(posedge clk) cycleCount <= cycleCount + 1;

	always @(posedge clk) begin
		if (ioValid && !sawDone) begin
			if (ioData === doneWord) sawDone = 1'b1;
			else ioWords.push_back(ioData);
		end
	end

	function automatic wordT encR(functT fn, regIdxT rs, regIdxT rt, regIdxT rd,
		logic [4:0] sh);
		return {opRType, rs, rt, rd, sh, fn};
	endfunction

	function automatic wordT encI(opcodeT op, regIdxT rs, regIdxT rt, logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	function automatic wordT encJ(logic [25:0] index);
		return {opJ, index};
	endfunction

	function automatic wordT signExt(logic [15:0] imm);
		return {{16{imm[15]}}, imm};
	endfunction

	task automatic stopFailed();
		$display("SOME TESTS FAILED");
		$fatal(1, "run stopped at the first error");
	endtask

	task automatic compareWord(input wordT got, input wordT exp, input string what);
		if (got !== exp) begin
			$display("Mismatch at time %0t: %s is %h, expected %h",
				$time, what, got, exp);
			stopFailed();
		end
	endtask

	task automatic compareCount(input int got, input int exp, input string what);
		if (got != exp) begin
			$display("Mismatch at time %0t: %s is %0d, expected %0d",
				$time, what, got, exp);
			stopFailed();
		end
	endtask

	task automatic emit(input wordT w);
		prog.push_back(w);
	endtask

	task automatic addExpected(input wordT w);
		expWords.push_back(w);
	endtask

	task automatic putConst(input regIdxT r, input wordT v);
		emit(encI(opLui, 5'd0, r, v[31:16]));
		emit(encI(opOri, r, r, v[15:0]));
	endtask

	task automatic putOut(input regIdxT r);
		emit(encI(opSw, 5'd30, r, 16'h0000)); // r30 holds the port address
	endtask

	task automatic startProgram();
		prog.delete();
		expWords.delete();
		emit(encI(opLui, 5'd0, 5'd30, 16'h8000));
	endtask

	task automatic finishProgram();
		putConst(5'd29, doneWord);
		putOut(5'd29);
		emit(encJ(26'(prog.size()))); // park on a jump to itself
		emit(32'h0000_0000);
	endtask

	task automatic runProgram(input bit withStalls);
		cycleBudget += prog.size() * 12 + 64;
		stall = 1'b1;
		foreach (prog[i]) begin
			progWe = 1'b1;
			progAddr = addrW'(i);
			progData = prog[i];
			@(posedge clk);
			#1;
		end
		progWe = 1'b0;
		rstN = 1'b0;
		repeat (16) @(posedge clk);
		#1;
		rstN = 1'b1;
		ioWords.delete();
		sawDone = 1'b0;
		// the first cycle out of reset already runs with the chosen stall level
		while (!sawDone) begin
			stall = withStalls && (($random(seed) & 1) != 0);
			@(posedge clk);
			#1;
		end
		stall = 1'b1;
		compareCount(ioWords.size(), expWords.size(), "number of I/O writes");
		foreach (expWords[i]) begin
			compareWord(ioWords[i], expWords[i], $sformatf("I/O word %0d", i));
		end
	endtask

	task automatic putRType(input functT fn, input logic [4:0] sh, input wordT exp);
		emit(encR(fn, 5'd1, 5'd2, 5'd3, sh));
		putOut(5'd3);
		addExpected(exp);
	endtask

	task automatic putIType(input opcodeT op, input logic [15:0] imm, input wordT exp);
		emit(encI(op, 5'd1, 5'd3, imm));
		putOut(5'd3);
		addExpected(exp);
	endtask

	task automatic putBranch(input opcodeT op, input regIdxT rt, input wordT x, input wordT y,
		input wordT slotVal, input wordT fallVal);
		bit taken;
		taken = (op == opJ) || (op == opBeq && x == y) || (op == opBne && x != y);
		if (op == opJ) emit(encJ(26'(prog.size() + 3)));
		else emit(encI(op, 5'd1, rt, 16'd2)); // lands one word past the slot
		putOut(5'd10); // delay slot
		putOut(5'd11);
		addExpected(slotVal);
		if (!taken) addExpected(fallVal);
	endtask

	task automatic runRTypeOps();
		wordT a, b;
		logic [4:0] sh;
		startProgram();
		repeat (2) begin
			a = $random(seed);
			b = $random(seed);
			sh = 5'($random(seed));
			putConst(5'd1, a);
			putConst(5'd2, b);
			putRType(fnAddu, 5'd0, a + b);
			putRType(fnSubu, 5'd0, a - b);
			putRType(fnAnd, 5'd0, a & b);
			putRType(fnOr, 5'd0, a | b);
			putRType(fnXor, 5'd0, a ^ b);
			putRType(fnSlt, 5'd0, wordT'($signed(a) < $signed(b)));
			putRType(fnSll, sh, b << sh);
			putRType(fnSrl, sh, b >> sh);
		end
		finishProgram();
		runProgram(1'b0);
	endtask

	task automatic immediateOps();
		wordT a;
		logic [15:0] neg, pos;
		startProgram();
		a = $random(seed);
		neg = 16'($random(seed)) | 16'h8000;
		pos = 16'($random(seed)) & 16'h7fff;
		putConst(5'd1, a);
		putIType(opAddiu, neg, a + signExt(neg));
		putIType(opAddiu, pos, a + signExt(pos));
		putIType(opSlti, neg, wordT'($signed(a) < $signed(signExt(neg))));
		putIType(opSlti, pos, wordT'($signed(a) < $signed(signExt(pos))));
		putIType(opAndi, neg, a & {16'h0000, neg});
		putIType(opOri, neg, a | {16'h0000, neg});
		putIType(opLui, neg, {neg, 16'h0000});
		finishProgram();
		runProgram(1'b0);
	endtask

	task automatic forwardingChain(input bit withStalls);
		wordT a, b;
		startProgram();
		a = $random(seed);
		b = $random(seed);
		putConst(5'd1, a);
		putConst(5'd2, b);
		emit(encR(fnAddu, 5'd1, 5'd2, 5'd3, 5'd0));
		emit(encR(fnSubu, 5'd3, 5'd1, 5'd4, 5'd0)); // r4 = b
		emit(encR(fnXor, 5'd4, 5'd3, 5'd5, 5'd0));
		putOut(5'd5);
		addExpected(b ^ (a + b));
		emit(encR(fnAddu, 5'd1, 5'd2, 5'd0, 5'd0)); // lost in r0
		emit(encR(fnOr, 5'd0, 5'd2, 5'd9, 5'd0));
		putOut(5'd9);
		addExpected(b);
		emit(encI(opSw, 5'd0, 5'd1, 16'h0010));
		emit(encI(opLw, 5'd0, 5'd6, 16'h0010));
		emit(encR(fnAddu, 5'd6, 5'd2, 5'd7, 5'd0)); // load use
		putOut(5'd7);
		addExpected(a + b);
		emit(encI(opLw, 5'd0, 5'd8, 16'h0010));
		putOut(5'd8);
		addExpected(a);
		finishProgram();
		runProgram(withStalls);
	endtask

	task automatic memoryReadBack(input bit withStalls);
		wordT vals[4];
		logic [15:0] offs[4] = '{16'h0000, 16'h0008, 16'h0014, 16'h002c};
		int order[4] = '{2, 0, 3, 1};
		startProgram();
		for (int k = 0; k < 4; k++) begin
			vals[k] = $random(seed);
			putConst(regIdxT'(k + 1), vals[k]);
			emit(encI(opSw, 5'd0, regIdxT'(k + 1), offs[k]));
		end
		for (int k = 0; k < 4; k++) begin
			emit(encI(opLw, 5'd0, regIdxT'(k + 5), offs[order[k]]));
			putOut(regIdxT'(k + 5));
			addExpected(vals[order[k]]);
		end
		finishProgram();
		runProgram(withStalls);
	endtask

	task automatic branchDelaySlot(input bit withStalls);
		wordT a, b, slotVal, fallVal;
		startProgram();
		a = $random(seed);
		b = a ^ 32'h0000_0100;
		slotVal = $random(seed);
		fallVal = $random(seed);
		putConst(5'd1, a);
		putConst(5'd2, a);
		putConst(5'd3, b);
		putConst(5'd10, slotVal);
		putConst(5'd11, fallVal);
		putBranch(opBeq, 5'd2, a, a, slotVal, fallVal);
		putBranch(opBeq, 5'd3, a, b, slotVal, fallVal);
		putBranch(opBne, 5'd2, a, a, slotVal, fallVal);
		putBranch(opBne, 5'd3, a, b, slotVal, fallVal);
		putBranch(opJ, 5'd0, a, a, slotVal, fallVal);
		finishProgram();
		runProgram(withStalls);
	endtask

	initial begin : watchdog
		wait (cycleCount > cycleBudget);
		$display("Timeout: a program did not finish within %0d clock cycles", cycleBudget);
		stopFailed();
	end

	initial begin : assertionWatch
		wait (i_mipsTop.i_coreChecker.failCount != 0);
		$display("An assertion in the core checker failed");
		stopFailed();
	end

	initial begin
		rstN = 1'b0;
		stall = 1'b1;
		progWe = 1'b0;
		progAddr = '0;
		progData = '0;
		repeat (16) @(posedge clk);
		#1;
		rstN = 1'b1;
		runRTypeOps();
		immediateOps();
		forwardingChain(1'b0);
		memoryReadBack(1'b0);
		branchDelaySlot(1'b0);
		forwardingChain(1'b1); // same programs again under a random stall pattern
		memoryReadBack(1'b1);
		branchDelaySlot(1'b1);
		if (i_mipsTop.i_coreChecker.failCount == 0) begin
			$display("ALL TESTS PASSED");
			$finish;
		end else begin
			$display("%0d assertion failures in the core checker",
				i_mipsTop.i_coreChecker.failCount);
			stopFailed();
		end
	end

endmodule

// ==== filelist.f ====
common/mipsIsaPkg.sv
common/mipsCtrlPkg.sv
common/execResultIf.sv
rtl/instDecoder.sv
rtl/regFile.sv
rtl/aluExec.sv
rtl/resultSel.sv
rtl/blockRam.sv
rtl/mipsTop.sv
dv/mipsCore_checker.sv
dv/mipsTb.sv
